/* vlog.f */
+incdir+.
can_reg_pkg.sv
can_core_pkg.sv
can_reg_decode.sv
can_reg_execute.sv
can_reg_result.sv
can_registers_top.sv
tb_clock_gen.sv
tb_can_registers.sv

/* tb_can_registers.sv */
// Testbench for the CAN host register file
// Drives host accesses and engine events while assertions check the responses
`timescale 1ns/1ps
`include "can_params.svh"

module tb_can_registers
  import can_reg_pkg::*, can_core_pkg::*;
();

  // Cycle budget of the test sequence and the fourfold limit on it
  localparam int TEST_CYCLES = 500;
  localparam int MAX_CYCLES  = 4 * TEST_CYCLES;
  // BTR0, BTR1, EWL, then acceptance codes and masks
  localparam logic [`CAN_AW-1:0] PROT_ADDR [11] = '{
    BTR0, BTR1, EWL, ACC_CODE0, ACC_CODE1, ACC_CODE2, ACC_CODE3,
    ACC_MASK0, ACC_MASK1, ACC_MASK2, ACC_MASK3
  };

  logic               clk;
  logic               rst;
  logic               re;
  logic               we;
  logic [`CAN_AW-1:0] addr_read;
  logic [`CAN_AW-1:0] addr_write;
  logic [`CAN_DW-1:0] data_in;
  logic [`CAN_DW-1:0] data_out;
  logic               irq_n;
  core_evt_t          evt;
  err_cnt_t           err_cnt;
  cfg_t               cfg;
  cmd_t               cmd;
  logic               we_rx_err_cnt;
  logic               we_tx_err_cnt;
  // Values accepted while in reset mode
  logic [`CAN_DW-1:0] shadow [11];
  logic [31:0]        lcg_state = 32'd15;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycles = 0;

  tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

  can_registers_top u_can_registers_top (
    .clk           (clk),
    .rst           (rst),
    .re            (re),
    .we            (we),
    .addr_read     (addr_read),
    .addr_write    (addr_write),
    .data_in       (data_in),
    .data_out      (data_out),
    .irq_n         (irq_n),
    .evt           (evt),
    .err_cnt       (err_cnt),
    .cfg           (cfg),
    .cmd           (cmd),
    .we_rx_err_cnt (we_rx_err_cnt),
    .we_tx_err_cnt (we_tx_err_cnt)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [7:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  // Configuration byte as seen on the engine side in PROT_ADDR order
  function automatic logic [7:0] cfg_byte(int idx);
    if (idx == 0)
      return cfg.timing[15:8];
    else if (idx == 1)
      return cfg.timing[7:0];
    else if (idx == 2)
      return cfg.ewl;
    else if (idx < 7)
      return cfg.acc_code[idx-3];
    else
      return cfg.acc_mask[idx-7];
  endfunction

  task automatic report_mismatch(input string name, input logic [7:0] exp,
                                 input logic [7:0] act);
    $display("Error %s: expected 0x%02h actual 0x%02h", name, exp, act);
    errors++;
  endtask

  task automatic check_value(input string name, input logic [7:0] exp,
                             input logic [7:0] act);
    checks++;
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  // One-cycle host write that returns on the falling edge after the update
  task automatic write_reg(input logic [`CAN_AW-1:0] addr, input logic [7:0] data);
    @(negedge clk);
    we         = 1'b1;
    addr_write = addr;
    data_in    = data;
    @(negedge clk);
    we = 1'b0;
  endtask

  // One-cycle host read with data_out compared under a mask before the next edge
  task automatic read_check(input string name, input logic [`CAN_AW-1:0] addr,
                            input logic [7:0] mask, input logic [7:0] exp);
    @(negedge clk);
    re        = 1'b1;
    addr_read = addr;
    #2;
    check_value(name, exp, data_out & mask);
    @(negedge clk);
    re = 1'b0;
  endtask

  ////////////////////
  // Protocol checks
  ////////////////////

  a_tx_req_set: assert property (
    @(posedge clk) disable iff (rst)
    (we && addr_write == COMMAND && data_in[TX_REQ] && !cfg.mode.reset_mode)
      |=> cmd.tx_request
  ) else report_mismatch("tx_req_set", 8'd1, 8'd0);

  a_tx_req_clear: assert property (
    @(posedge clk) disable iff (rst)
    (cmd.tx_request && evt.sample_point) |=> !cmd.tx_request
  ) else report_mismatch("tx_req_clear", 8'd0, 8'd1);

  // Release is a single-cycle pulse
  a_release_pulse: assert property (
    @(posedge clk) disable iff (rst)
    cmd.release_buffer |=> !cmd.release_buffer
  ) else report_mismatch("release_pulse", 8'd0, 8'd1);

  a_rx_irq_fall: assert property (
    @(posedge clk) disable iff (rst)
    ($fell(evt.info_empty) && cfg.irq_en[0] && !cfg.mode.reset_mode) |-> ##[1:2] !irq_n
  ) else report_mismatch("rx_irq_fall", 8'd0, 8'd1);

  // Line released after an IRQ read or a buffer release
  a_irq_release: assert property (
    @(posedge clk) disable iff (rst)
    ((re && addr_read == IRQ) || cmd.release_buffer) |=> irq_n
  ) else report_mismatch("irq_release", 8'd1, 8'd0);

  // Counter write strobes pulse only for a host write in reset mode
  a_err_cnt_we: assert property (
    @(posedge clk) disable iff (rst)
    we_rx_err_cnt == (we && addr_write == RXERR && cfg.mode.reset_mode) &&
    we_tx_err_cnt == (we && addr_write == TXERR && cfg.mode.reset_mode)
  ) else
  begin
    $display("Error err_cnt_we: counter write strobe does not follow the host write");
    errors++;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial
  begin
    re         = 1'b0;
    we         = 1'b0;
    addr_read  = '0;
    addr_write = '0;
    data_in    = '0;
    err_cnt    = '0;
    // Idle engine with an empty receive FIFO
    evt            = '0;
    evt.info_empty = 1'b1;
    wait (!rst);

    // Reset values
    read_check("reset_mode", MODE, 8'hFF, 8'h01);
    read_check("reset_status", STATUS, 8'hFF, 8'h0C);
    read_check("reset_ewl", EWL, 8'hFF, 8'd96);
    read_check("reset_irq", IRQ, 8'hFF, 8'h00);
    check_value("reset_irq_n", 8'd1, {7'd0, irq_n});

    // Protected registers accept writes in reset mode
    for (int i = 0; i < 11; i++)
    begin
      shadow[i] = next_random();
      write_reg(PROT_ADDR[i], shadow[i]);
    end
    // Error counter writes strobe the engine
    write_reg(RXERR, next_random());
    write_reg(TXERR, next_random());
    for (int i = 0; i < 11; i++)
    begin
      read_check($sformatf("prot_read_%0d", i), PROT_ADDR[i], 8'hFF, shadow[i]);
      check_value($sformatf("prot_cfg_%0d", i), shadow[i], cfg_byte(i));
    end
    // Later writes must not land once reset mode is left
    write_reg(MODE, 8'h00);
    read_check("mode_cleared", MODE, 8'hFF, 8'h00);
    for (int i = 0; i < 11; i++)
      write_reg(PROT_ADDR[i], next_random());
    write_reg(RXERR, next_random());
    write_reg(TXERR, next_random());
    for (int i = 0; i < 11; i++)
      read_check($sformatf("prot_locked_%0d", i), PROT_ADDR[i], 8'hFF, shadow[i]);
    // Error counters read back from the engine side
    err_cnt.rx_err_cnt = next_random();
    err_cnt.tx_err_cnt = next_random();
    read_check("rx_err_cnt", RXERR, 8'hFF, err_cnt.rx_err_cnt);
    read_check("tx_err_cnt", TXERR, 8'hFF, err_cnt.tx_err_cnt);
    data_in = next_random();
    write_reg(IRQ_EN, data_in);
    read_check("irq_en_open", IRQ_EN, 8'hFF, data_in);
    // Receive, error, overrun and bus-error enables
    write_reg(IRQ_EN, 8'h8D);

    // Transmit request and its clear on a sample point
    write_reg(COMMAND, 8'h01);
    check_value("tx_req_high", 8'd1, {7'd0, cmd.tx_request});
    read_check("tx_buf_locked", STATUS, 8'h04, 8'h00);
    @(negedge clk);
    evt.sample_point = 1'b1;
    @(negedge clk);
    evt.sample_point = 1'b0;
    check_value("tx_req_low", 8'd0, {7'd0, cmd.tx_request});
    write_reg(COMMAND, 8'h04);
    check_value("release_high", 8'd1, {7'd0, cmd.release_buffer});
    @(negedge clk);
    check_value("release_low", 8'd0, {7'd0, cmd.release_buffer});

    // Receive interrupt survives IRQ reads until the buffer is released
    @(negedge clk);
    evt.info_empty = 1'b0;
    repeat (2) @(negedge clk);
    check_value("rx_irq_n_low", 8'd0, {7'd0, irq_n});
    read_check("rx_irq_set", IRQ, 8'hFF, 8'h01);
    read_check("rx_irq_kept", IRQ, 8'hFF, 8'h01);
    @(negedge clk);
    check_value("rx_irq_n_again", 8'd0, {7'd0, irq_n});
    evt.info_empty = 1'b1;
    write_reg(COMMAND, 8'h04);
    @(negedge clk);
    check_value("rx_irq_n_high", 8'd1, {7'd0, irq_n});
    read_check("rx_irq_cleared", IRQ, 8'hFF, 8'h00);

    // Overrun status and interrupt
    @(negedge clk);
    evt.overrun = 1'b1;
    @(negedge clk);
    evt.overrun = 1'b0;
    read_check("ovr_status_set", STATUS, 8'h02, 8'h02);
    read_check("ovr_irq_set", IRQ, 8'hFF, 8'h08);
    read_check("ovr_irq_cleared", IRQ, 8'hFF, 8'h00);
    write_reg(COMMAND, 8'h08);
    check_value("clr_ovr_high", 8'd1, {7'd0, cmd.clear_data_overrun});
    read_check("ovr_status_cleared", STATUS, 8'h02, 8'h00);

    // One read clears both the error and the bus-error flag
    @(negedge clk);
    evt.error_status = 1'b1;
    @(negedge clk);
    evt.error_status      = 1'b0;
    evt.set_bus_error_irq = 1'b1;
    @(negedge clk);
    evt.set_bus_error_irq = 1'b0;
    read_check("err_bus_irq_set", IRQ, 8'hFF, 8'h84);
    read_check("err_bus_irq_cleared", IRQ, 8'hFF, 8'h00);
    // Bus error ignored once disabled
    write_reg(IRQ_EN, 8'h0D);
    @(negedge clk);
    evt.set_bus_error_irq = 1'b1;
    @(negedge clk);
    evt.set_bus_error_irq = 1'b0;
    read_check("bus_irq_masked", IRQ, 8'hFF, 8'h00);

    repeat (4) @(negedge clk);
    $display("Summary: %0d value checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
// Clock and reset source for the CAN register file testbench
// 8 ns clock, reset held high over the first two rising edges
`timescale 1ns/1ps

module tb_clock_gen
(
  output logic clk,
  output logic rst
);

  // Free-running clock, first rising edge at 4 ns
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* can_registers_top.sv */
// Top level of the CAN host register file
// Connects address decode, register execute and status/result stages
`timescale 1ns/1ps
`include "can_params.svh"

module can_registers_top
  import can_reg_pkg::*, can_core_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  // Host port, one cycle per access
  input  logic               re,
  input  logic               we,
  input  logic [`CAN_AW-1:0] addr_read,
  input  logic [`CAN_AW-1:0] addr_write,
  input  logic [`CAN_DW-1:0] data_in,
  output logic [`CAN_DW-1:0] data_out,
  output logic               irq_n,
  // Protocol engine side
  input  core_evt_t          evt,
  input  err_cnt_t           err_cnt,
  output cfg_t               cfg,
  output cmd_t               cmd,
  output logic               we_rx_err_cnt,
  output logic               we_tx_err_cnt
);

  reg_we_t reg_we;
  logic    read_irq;

  can_reg_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .we         (we),
    .re         (re),
    .addr_write (addr_write),
    .addr_read  (addr_read),
    .mode       (cfg.mode),
    .reg_we     (reg_we),
    .read_irq   (read_irq)
  );

  can_reg_execute u_execute (
    .clk           (clk),
    .rst           (rst),
    .data_in       (data_in),
    .reg_we        (reg_we),
    .evt           (evt),
    .cfg           (cfg),
    .cmd           (cmd),
    .we_rx_err_cnt (we_rx_err_cnt),
    .we_tx_err_cnt (we_tx_err_cnt)
  );

  can_reg_result u_result (
    .clk       (clk),
    .rst       (rst),
    .evt       (evt),
    .err_cnt   (err_cnt),
    .cfg       (cfg),
    .cmd       (cmd),
    .read_irq  (read_irq),
    .addr_read (addr_read),
    .data_out  (data_out),
    .irq_n     (irq_n)
  );

endmodule

/* can_reg_result.sv */
// Status, interrupt flags and read-back mux of the CAN register file
// Watches engine events, drives irq_n and forms the host read data
`timescale 1ns/1ps
`include "can_params.svh"

module can_reg_result
  import can_reg_pkg::*, can_core_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  core_evt_t          evt,
  input  err_cnt_t           err_cnt,
  input  cfg_t               cfg,
  input  cmd_t               cmd,
  input  logic               read_irq,
  input  logic [`CAN_AW-1:0] addr_read,
  output logic [`CAN_DW-1:0] data_out,
  output logic               irq_n
);

  logic               reset_mode;
  // Delayed copies for edge detection
  logic               tx_successful_q;
  logic               overrun_q;
  logic               tx_buf_status_q;
  logic               error_status_q;
  logic               bus_off_q;
  logic               err_passive_q;
  // Status bits kept here
  logic               tx_complete;
  logic               tx_buf_status;
  logic               overrun_status;
  logic               rx_buf_status;
  // Interrupt flags
  logic               receive_irq;
  logic               transmit_irq;
  logic               error_irq;
  logic               overrun_irq;
  logic               err_passive_irq;
  logic               arb_lost_irq;
  logic               bus_error_irq;
  logic               irq;
  logic [`CAN_DW-1:0] status_byte;
  logic [`CAN_DW-1:0] irq_byte;

  assign reset_mode = cfg.mode.reset_mode;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      tx_successful_q <= 1'b0;
      overrun_q       <= 1'b0;
      tx_buf_status_q <= 1'b1;
      error_status_q  <= 1'b0;
      bus_off_q       <= 1'b0;
      err_passive_q   <= 1'b0;
    end
    else
    begin
      tx_successful_q <= evt.tx_successful;
      overrun_q       <= evt.overrun;
      tx_buf_status_q <= tx_buf_status;
      error_status_q  <= evt.error_status;
      bus_off_q       <= evt.node_bus_off;
      err_passive_q   <= evt.node_error_passive;
    end
  end

  ////////////////////
  // Status bits
  ////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      tx_complete    <= 1'b1;
      tx_buf_status  <= 1'b1;
      overrun_status <= 1'b0;
      rx_buf_status  <= 1'b0;
    end
    else
    begin
      // Done on a new success or an abort, pending on a request
      if ((evt.tx_successful & ~tx_successful_q) | cmd.abort_tx)
        tx_complete <= 1'b1;
      else if (cmd.tx_request)
        tx_complete <= 1'b0;
      // Buffer locked while a request is pending
      if (cmd.tx_request)
        tx_buf_status <= 1'b0;
      else if (reset_mode | ~evt.need_to_tx)
        tx_buf_status <= 1'b1;
      if (evt.overrun & ~overrun_q)
        overrun_status <= 1'b1;
      else if (reset_mode | cmd.clear_data_overrun)
        overrun_status <= 1'b0;
      if (reset_mode | cmd.release_buffer)
        rx_buf_status <= 1'b0;
      else if (~evt.info_empty)
        rx_buf_status <= 1'b1;
    end
  end

  ////////////////////
  // Interrupt flags
  ////////////////////

  // Enable bits follow the IRQ byte layout, bit 4 unused
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      receive_irq     <= 1'b0;
      transmit_irq    <= 1'b0;
      error_irq       <= 1'b0;
      overrun_irq     <= 1'b0;
      err_passive_irq <= 1'b0;
      arb_lost_irq    <= 1'b0;
      bus_error_irq   <= 1'b0;
    end
    else
    begin
      // Receive flag survives an IRQ read, only a release clears it
      if (~evt.info_empty & ~receive_irq & cfg.irq_en[0])
        receive_irq <= 1'b1;
      else if (reset_mode | cmd.release_buffer)
        receive_irq <= 1'b0;
      if (reset_mode | read_irq)
        transmit_irq <= 1'b0;
      else if (tx_buf_status & ~tx_buf_status_q & cfg.irq_en[1])
        transmit_irq <= 1'b1;
      // Any change of error or bus-off state
      if (((evt.error_status ^ error_status_q) | (evt.node_bus_off ^ bus_off_q)) &
          cfg.irq_en[2])
        error_irq <= 1'b1;
      else if (read_irq)
        error_irq <= 1'b0;
      if (evt.overrun & ~overrun_q & cfg.irq_en[3])
        overrun_irq <= 1'b1;
      else if (reset_mode | read_irq)
        overrun_irq <= 1'b0;
      // Entering passive, or leaving it back to active
      if (((evt.node_error_passive & ~err_passive_q) |
           (~evt.node_error_passive & err_passive_q & evt.node_error_active)) &
          cfg.irq_en[5])
        err_passive_irq <= 1'b1;
      else if (reset_mode | read_irq)
        err_passive_irq <= 1'b0;
      if (evt.set_arbitration_lost_irq & cfg.irq_en[6])
        arb_lost_irq <= 1'b1;
      else if (reset_mode | read_irq)
        arb_lost_irq <= 1'b0;
      if (evt.set_bus_error_irq & cfg.irq_en[7])
        bus_error_irq <= 1'b1;
      else if (reset_mode | read_irq)
        bus_error_irq <= 1'b0;
    end
  end

  assign irq = receive_irq | transmit_irq | error_irq | overrun_irq |
               err_passive_irq | arb_lost_irq | bus_error_irq;

  // High for at least one cycle after a read or release
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      irq_n <= 1'b1;
    else if (read_irq | cmd.release_buffer)
      irq_n <= 1'b1;
    else
      irq_n <= ~irq;
  end

  // The line only goes low behind a pending flag
  a_irq_has_source: assert property (
    @(posedge clk) disable iff (rst)
    !irq_n |-> $past(irq)
  );

  ////////////////////
  // Read-back
  ////////////////////

  assign status_byte = {evt.node_bus_off, evt.error_status, evt.transmit_status,
                        evt.receive_status, tx_complete, tx_buf_status,
                        overrun_status, rx_buf_status};
  assign irq_byte    = {bus_error_irq, arb_lost_irq, err_passive_irq, 1'b0,
                        overrun_irq, error_irq, transmit_irq, receive_irq};

  always_comb
  begin
    case (addr_read)
      MODE:   data_out = {4'b0000, cfg.mode};
      STATUS: data_out = status_byte;
      IRQ:    data_out = irq_byte;
      IRQ_EN: data_out = cfg.irq_en;
      BTR0:   data_out = {cfg.timing.sjw, cfg.timing.baud_presc};
      BTR1:   data_out = {cfg.timing.triple_sampling, cfg.timing.tseg2, cfg.timing.tseg1};
      EWL:    data_out = cfg.ewl;
      RXERR:  data_out = err_cnt.rx_err_cnt;
      TXERR:  data_out = err_cnt.tx_err_cnt;
      ACC_CODE0, ACC_CODE1, ACC_CODE2, ACC_CODE3:
        data_out = cfg.acc_code[addr_read[1:0]];
      ACC_MASK0, ACC_MASK1, ACC_MASK2, ACC_MASK3:
        data_out = cfg.acc_mask[addr_read[1:0]];
      // COMMAND and unmapped addresses
      default: data_out = '0;
    endcase
  end

endmodule

/* can_reg_execute.sv */
// Configuration and command registers of the CAN register file
// Holds mode, enables, timing and filters, and the self-clearing commands
`timescale 1ns/1ps
`include "can_params.svh"

module can_reg_execute
  import can_reg_pkg::*, can_core_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [`CAN_DW-1:0] data_in,
  input  reg_we_t            reg_we,
  input  core_evt_t          evt,
  output cfg_t               cfg,
  output cmd_t               cmd,
  output logic               we_rx_err_cnt,
  output logic               we_tx_err_cnt
);

  logic             reset_mode;
  // Raw command bits and their per-bit clear terms
  logic [SELF_RX:0] command;
  logic [SELF_RX:0] cmd_clr;
  logic             tx_request;
  logic             abort_tx;
  logic             self_rx_q;
  logic             single_shot_q;
  // End of the current frame
  logic             tx_done;

  assign reset_mode = cfg.mode.reset_mode;
  assign tx_done    = ~evt.tx_state & evt.tx_state_q;

  ////////////////////
  // Configuration
  ////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cfg                 <= '0;
      cfg.mode.reset_mode <= 1'b1;
      cfg.ewl             <= `CAN_EWL_RESET;
    end
    else
    begin
      // Bus-off from the engine wins over a host write
      if (evt.set_reset_mode)
        cfg.mode.reset_mode <= 1'b1;
      else if (reg_we.mode)
        cfg.mode.reset_mode <= data_in[0];
      if (reg_we.mode_prot)
        {cfg.mode.acc_filter, cfg.mode.self_test, cfg.mode.listen_only} <= data_in[3:1];
      if (reg_we.irq_en)
        cfg.irq_en <= data_in;
      if (reg_we.btr0)
        {cfg.timing.sjw, cfg.timing.baud_presc} <= data_in;
      if (reg_we.btr1)
        {cfg.timing.triple_sampling, cfg.timing.tseg2, cfg.timing.tseg1} <= data_in;
      if (reg_we.ewl)
        cfg.ewl <= data_in;
      for (int i = 0; i < `CAN_ACC_BYTES; i++)
      begin
        if (reg_we.acc_code[i])
          cfg.acc_code[i] <= data_in;
        if (reg_we.acc_mask[i])
          cfg.acc_mask[i] <= data_in;
      end
    end
  end

  // Counter writes are applied inside the engine
  assign we_rx_err_cnt = reg_we.rx_err_cnt;
  assign we_tx_err_cnt = reg_we.tx_err_cnt;

  ////////////////////
  // Command register
  ////////////////////

  always_comb
  begin
    // Transmit requests drop on the edge after a sample point
    cmd_clr[TX_REQ]  = reset_mode | (command[TX_REQ] & evt.sample_point);
    cmd_clr[SELF_RX] = reset_mode | (command[SELF_RX] & evt.sample_point);
    // Abort holds until it takes effect on the bus
    cmd_clr[ABORT]   = reset_mode |
                       (evt.sample_point & (tx_request | (abort_tx & ~evt.transmitting)));
    // Release and clear overrun are one-cycle pulses
    cmd_clr[RELEASE] = reset_mode | command[RELEASE] | command[CLR_OVR];
    cmd_clr[CLR_OVR] = reset_mode | command[RELEASE] | command[CLR_OVR];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      command <= '0;
    else
    begin
      for (int i = 0; i <= SELF_RX; i++)
      begin
        if (cmd_clr[i])
          command[i] <= 1'b0;
        else if (reg_we.command)
          command[i] <= data_in[i];
      end
    end
  end

  // Self reception counts as a transmit request
  assign tx_request = command[TX_REQ] | command[SELF_RX];
  assign abort_tx   = command[ABORT] & ~tx_request;

  // Side flags held until the frame ends
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      self_rx_q     <= 1'b0;
      single_shot_q <= 1'b0;
    end
    else
    begin
      if (command[SELF_RX] & ~command[TX_REQ])
        self_rx_q <= 1'b1;
      else if (tx_done)
        self_rx_q <= 1'b0;
      // Request plus abort in one write means single shot
      if (tx_request & command[ABORT] & evt.sample_point)
        single_shot_q <= 1'b1;
      else if (tx_done)
        single_shot_q <= 1'b0;
    end
  end

  always_comb
  begin
    cmd.tx_request         = tx_request;
    cmd.abort_tx           = abort_tx;
    cmd.release_buffer     = command[RELEASE];
    cmd.clear_data_overrun = command[CLR_OVR];
    cmd.self_rx_request    = self_rx_q;
    cmd.single_shot        = single_shot_q;
  end

  // The engine never sees abort and request together
  a_abort_vs_request: assert property (
    @(posedge clk) disable iff (rst)
    !(cmd.abort_tx && cmd.tx_request)
  );

endmodule

/* can_reg_decode.sv */
// Host address decode of the CAN register file
// Turns a host write into per-register strobes and flags reads of IRQ
`timescale 1ns/1ps
`include "can_params.svh"

module can_reg_decode
  import can_reg_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               we,
  input  logic               re,
  input  logic [`CAN_AW-1:0] addr_write,
  input  logic [`CAN_AW-1:0] addr_read,
  input  mode_t              mode,
  output reg_we_t            reg_we,
  output logic               read_irq
);

  // Write allowed to timing, limit, counter and filter registers
  logic prot_ok;

  assign prot_ok = mode.reset_mode;

  ////////////////////
  // Write decode
  ////////////////////

  always_comb
  begin
    reg_we = '0;
    if (we)
    begin
      case (addr_write)
        MODE:
        begin
          // Bit 0 always writable, bits 3:1 only in reset mode
          reg_we.mode      = 1'b1;
          reg_we.mode_prot = prot_ok;
        end
        COMMAND: reg_we.command = 1'b1;
        IRQ_EN:  reg_we.irq_en = 1'b1;
        BTR0:    reg_we.btr0 = prot_ok;
        BTR1:    reg_we.btr1 = prot_ok;
        EWL:     reg_we.ewl = prot_ok;
        RXERR:   reg_we.rx_err_cnt = prot_ok;
        TXERR:   reg_we.tx_err_cnt = prot_ok;
        // Low address bits select the filter byte
        ACC_CODE0, ACC_CODE1, ACC_CODE2, ACC_CODE3:
          reg_we.acc_code[addr_write[1:0]] = prot_ok;
        ACC_MASK0, ACC_MASK1, ACC_MASK2, ACC_MASK3:
          reg_we.acc_mask[addr_write[1:0]] = prot_ok;
        default: reg_we = '0;
      endcase
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  // Reading IRQ clears flags in the result stage
  assign read_irq = re && (addr_read == IRQ);

  // Only one register is written per host cycle
  // mode_prot rides along with mode and is left out
  a_one_reg_we: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(reg_we[$bits(reg_we_t)-2:0])
  );

endmodule

/* can_core_pkg.sv */
// Signals exchanged between the register file and the CAN protocol engine
// Imported by modules that watch engine events or read the error counters
`include "can_params.svh"

package can_core_pkg;

  // Status and event inputs from the protocol engine
  typedef struct packed {
    // Bit timing and transmitter activity
    logic sample_point;
    logic transmitting;
    // Forces the controller back into reset mode
    logic set_reset_mode;
    // Bus state, shown in STATUS
    logic node_bus_off;
    logic error_status;
    logic transmit_status;
    logic receive_status;
    // Transmit and receive progress
    logic tx_successful;
    logic need_to_tx;
    logic overrun;
    logic info_empty;
    // One-cycle interrupt requests
    logic set_bus_error_irq;
    logic set_arbitration_lost_irq;
    // Error confinement state
    logic node_error_passive;
    logic node_error_active;
    // Transmit state and its delayed copy, falling edge ends a frame
    logic tx_state;
    logic tx_state_q;
  } core_evt_t;

  // Error counters kept by the engine, read back by the host
  typedef struct packed {
    logic [`CAN_DW-1:0] rx_err_cnt;
    logic [`CAN_DW-1:0] tx_err_cnt;
  } err_cnt_t;

endpackage

/* can_reg_pkg.sv */
// Host-side register map and register contents of the CAN controller
// Imported by every register file module that decodes or holds registers
`include "can_params.svh"

package can_reg_pkg;

  // Byte addresses of the extended mode register map
  typedef enum logic [`CAN_AW-1:0] {
    MODE      = 8'd0,
    COMMAND   = 8'd1,
    STATUS    = 8'd2,
    IRQ       = 8'd3,
    IRQ_EN    = 8'd4,
    BTR0      = 8'd6,
    BTR1      = 8'd7,
    EWL       = 8'd13,
    RXERR     = 8'd14,
    TXERR     = 8'd15,
    ACC_CODE0 = 8'd16,
    ACC_CODE1 = 8'd17,
    ACC_CODE2 = 8'd18,
    ACC_CODE3 = 8'd19,
    ACC_MASK0 = 8'd20,
    ACC_MASK1 = 8'd21,
    ACC_MASK2 = 8'd22,
    ACC_MASK3 = 8'd23
  } can_addr_e;

  // Bit positions inside the command byte
  typedef enum logic [2:0] {
    TX_REQ  = 3'd0,
    ABORT   = 3'd1,
    RELEASE = 3'd2,
    CLR_OVR = 3'd3,
    SELF_RX = 3'd4
  } can_cmd_e;

  // Mode byte, reset_mode sits in bit 0
  typedef struct packed {
    logic acc_filter;
    logic self_test;
    logic listen_only;
    logic reset_mode;
  } mode_t;

  // BTR0 in the upper byte, BTR1 in the lower byte
  typedef struct packed {
    logic [1:0] sjw;
    logic [5:0] baud_presc;
    logic       triple_sampling;
    logic [2:0] tseg2;
    logic [3:0] tseg1;
  } bus_timing_t;

  // One strobe per writable register
  // mode_prot covers mode bits 3:1 and is kept as the top field
  typedef struct packed {
    logic                      mode_prot;
    logic                      mode;
    logic                      command;
    logic                      irq_en;
    logic                      btr0;
    logic                      btr1;
    logic                      ewl;
    logic                      rx_err_cnt;
    logic                      tx_err_cnt;
    logic [`CAN_ACC_BYTES-1:0] acc_code;
    logic [`CAN_ACC_BYTES-1:0] acc_mask;
  } reg_we_t;

  // Everything the host configures
  typedef struct packed {
    mode_t                                  mode;
    logic [`CAN_DW-1:0]                     irq_en;
    bus_timing_t                            timing;
    logic [`CAN_DW-1:0]                     ewl;
    logic [`CAN_ACC_BYTES-1:0][`CAN_DW-1:0] acc_code;
    logic [`CAN_ACC_BYTES-1:0][`CAN_DW-1:0] acc_mask;
  } cfg_t;

  // Live command outputs towards the protocol engine
  typedef struct packed {
    logic tx_request;
    logic abort_tx;
    logic release_buffer;
    logic clear_data_overrun;
    logic self_rx_request;
    logic single_shot;
  } cmd_t;

endpackage

/* can_params.svh */
// Widths and reset values shared by the CAN register file and its testbench
// Include wherever a bus width or a register reset value is needed
`ifndef CAN_PARAMS_SVH
`define CAN_PARAMS_SVH

////////////////////
// Host port widths
////////////////////

// Register data width
`define CAN_DW 8

// Register address width
`define CAN_AW 8

////////////////////
// Register contents
////////////////////

// Error warning limit after power-up
`define CAN_EWL_RESET 8'd96

// Acceptance code bytes, same count for the mask bytes
`define CAN_ACC_BYTES 4

`endif
